// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= turfio_cin_tb
DUT_TOP   ?= turfio_cin_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)
	$(VERILATOR) --lint-only --top-module $(DUT_TOP) design/turfio_pkg.sv \
		design/cin_lane_align.sv design/cin_train_monitor.sv \
		design/cin_response_mux.sv design/turfio_ctl_regs.sv design/turfio_cin_top.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/turfio_cin_assertions.sv ====
`default_nettype none

module turfio_cin_assertions
    import turfio_pkg::*;
(
    input wire                cin_clk_i,
    input wire                rst,
    input wire                valid_i,
    input wire [CREDIT_W-1:0] credit_i,
    input wire                req_i,
    input wire                ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // a word on the stream must own a credit
    valid_has_credit: assert property (@(posedge cin_clk_i) disable iff (rst)
        valid_i |-> (credit_i != '0))
        else $error("response valid with zero credits");

    credit_bounded: assert property (@(posedge cin_clk_i) disable iff (rst)
        credit_i <= CREDIT_W'(RESP_CREDITS))
        else $error("credit count above the reset grant");

    // ack exactly one cycle after each request, and never without one
    ack_follows_req: assert property (@(posedge cin_clk_i) disable iff (rst)
        req_i |=> ack_i)
        else $error("register request not acknowledged on the next cycle");

    ack_has_req: assert property (@(posedge cin_clk_i) disable iff (rst)
        ack_i |-> $past(req_i))
        else $error("register acknowledge without a request");

endmodule

bind cin_response_mux turfio_cin_assertions u_mux_assert (
    .cin_clk_i (cin_clk_i),
    .rst       (rst),
    .valid_i   (resp_valid_o),
    .credit_i  (credit_cnt),
    .req_i     (1'b0),
    .ack_i     (1'b0)
);

bind turfio_ctl_regs turfio_cin_assertions u_regs_assert (
    .cin_clk_i (cin_clk_i),
    .rst       (rst),
    .valid_i   (1'b0),
    .credit_i  (CREDIT_W'(0)),
    .req_i     (reg_wr_i || reg_rd_i),
    .ack_i     (reg_ack_o)
);

`default_nettype wire

// ==== bench/turfio_cin_tb.sv ====
`default_nettype none

module turfio_cin_tb
    import turfio_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SRC_TRAIN = 0;
    localparam int SRC_CORRUPT = 1;
    localparam int SRC_DATA = 2;
    localparam int NUM_ROWS = 7;
    localparam int TEST_INTERVAL = 16;
    // three intervals leave the second latched count clean
    localparam int SETTLE_CYCLES = 3 * TEST_INTERVAL * NIBBLES_PER_WORD + 32;

    typedef struct {
        int lane;
        int skew;
        int src;
        int count;
        int exp_res;
    } row_t;

    logic cin_clk_i = 1'b0;
    logic rst;
    logic reg_wr_i;
    logic reg_rd_i;
    reg_addr_t reg_addr_i;
    word_t reg_wdata_i;
    logic reg_ack_o;
    word_t reg_rdata_o;
    logic [NUM_LANES*LANE_W-1:0] lane_nibble_i;
    logic resp_valid_o;
    lane_idx_t resp_lane_o;
    word_t resp_data_o;
    logic resp_credit_i;

    row_t rows [NUM_ROWS];
    // per lane bit stream with bit 0 going out first
    logic [95:0] lane_buf [NUM_LANES];
    int lane_fill [NUM_LANES];
    int word_idx [NUM_LANES];
    int corrupt_k [NUM_LANES];
    int data_left [NUM_LANES];
    int skew_req [NUM_LANES];
    logic [NUM_LANES-1:0] restart_req;
    // model of the aligner phase counter
    int ph;
    word_t exp_q [$];
    word_t rx_data [$];
    lane_idx_t rx_lane [$];
    int data_seen;
    logic credit_en;
    int credit_kick;
    int errors;
    int checks;
    int tests;

    turfio_cin_top turfio_cin_top_i (
        .cin_clk_i     (cin_clk_i),
        .rst           (rst),
        .reg_wr_i      (reg_wr_i),
        .reg_rd_i      (reg_rd_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .reg_ack_o     (reg_ack_o),
        .reg_rdata_o   (reg_rdata_o),
        .lane_nibble_i (lane_nibble_i),
        .resp_valid_o  (resp_valid_o),
        .resp_lane_o   (resp_lane_o),
        .resp_data_o   (resp_data_o),
        .resp_credit_i (resp_credit_i)
    );

    always #20 cin_clk_i = ~cin_clk_i;

    // held at 0 through reset like the DUT counter
    always @(posedge cin_clk_i) begin
        if (rst) begin
            ph <= 0;
        end else begin
            ph <= (ph + 1) % NIBBLES_PER_WORD;
        end
    end

    // next word of a lane from random data or from training
    function automatic word_t next_word(input int l);
        word_t w;
        w = TRAIN_WORD;
        if (data_left[l] > 0) begin
            w = $urandom;
            exp_q.push_back(w);
            data_left[l]--;
        end else if ((word_idx[l] % TEST_INTERVAL) < corrupt_k[l]) begin
            // k bad words in any 16 in a row
            w = TRAIN_WORD ^ (32'h1 << ($urandom % 32));
        end
        word_idx[l]++;
        return w;
    endfunction

    // lane streams where a restart prepends the skew at phase 0
    always @(negedge cin_clk_i) begin : drive_lanes
        word_t w;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (restart_req[l] && ph == 0) begin
                lane_buf[l] = '0;
                lane_fill[l] = skew_req[l];
                word_idx[l] = 0;
                restart_req[l] = 1'b0;
            end
            // top up with a whole word once less than a nibble is left
            if (lane_fill[l] < LANE_W) begin
                w = next_word(l);
                lane_buf[l] = lane_buf[l] | ({64'b0, w} << lane_fill[l]);
                lane_fill[l] = lane_fill[l] + WORD_W;
            end
            lane_nibble_i[l*LANE_W +: LANE_W] = lane_buf[l][LANE_W-1:0];
            lane_buf[l] = lane_buf[l] >> LANE_W;
            lane_fill[l] = lane_fill[l] - LANE_W;
        end
    end

    // response consumer returns one credit per word when enabled
    always @(negedge cin_clk_i) begin
        resp_credit_i = 1'b0;
        if (!rst && resp_valid_o) begin
            rx_data.push_back(resp_data_o);
            rx_lane.push_back(resp_lane_o);
            if (resp_data_o != TRAIN_WORD) data_seen++;
            if (credit_en) resp_credit_i = 1'b1;
        end
        // extra credits handed back one per cycle
        if (credit_kick > 0 && !resp_credit_i) begin
            resp_credit_i = 1'b1;
            credit_kick--;
        end
    end

    initial begin
        #1ms;
        $display("watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $finish;
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_errcnt(input string name, input errcnt_t exp, input errcnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_lane(input string name, input lane_idx_t exp, input lane_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    function automatic reg_addr_t map_addr(input int lane, input int reg_off);
        return reg_addr_t'(int'(ADDR_LANE_BASE) + lane * LANE_STRIDE + reg_off);
    endfunction

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) @(negedge cin_clk_i);
    endtask

    // single request cycle and the wait for its ack
    task automatic reg_access(input logic wr, input reg_addr_t a, input word_t d,
                              output word_t q);
        int waited;
        @(negedge cin_clk_i);
        reg_wr_i = wr;
        reg_rd_i = !wr;
        reg_addr_i = a;
        reg_wdata_i = d;
        @(negedge cin_clk_i);
        reg_wr_i = 1'b0;
        reg_rd_i = 1'b0;
        waited = 1;
        while (!reg_ack_o && waited < 8) begin
            @(negedge cin_clk_i);
            waited++;
        end
        if (!reg_ack_o) begin
            errors++;
            $display("no register acknowledge for address %h at %0t", a, $time);
        end else if (waited != 1) begin
            errors++;
            $display("register acknowledge came %0d cycles after the request", waited);
        end
        q = reg_rdata_o;
    endtask

    task automatic reg_write(input reg_addr_t a, input word_t d);
        word_t unused;
        reg_access(1'b1, a, d, unused);
    endtask

    task automatic restart_lane(input int l, input int s);
        int t;
        skew_req[l] = s;
        restart_req[l] = 1'b1;
        t = 0;
        while (restart_req[l] && t < 64) begin
            @(negedge cin_clk_i);
            t++;
        end
        if (restart_req[l]) begin
            errors++;
            $display("lane %0d stream did not restart", l);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %-16s %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic test_registers();
        word_t q;
        word_t offs;
        word_t intv;
        word_t ctrl [NUM_LANES];
        reg_addr_t holes [5];
        int e0;
        e0 = errors;
        holes = '{reg_addr_t'('h03), reg_addr_t'('h0F), map_addr(0, 3),
                  map_addr(1, LANE_BITSLIP), reg_addr_t'('h3F)};
        offs = $urandom & 32'h7;
        intv = $urandom & 32'hFFFF;
        reg_write(ADDR_GLOBAL, offs);
        reg_write(ADDR_INTERVAL, intv);
        for (int l = 0; l < NUM_LANES; l++) begin
            ctrl[l] = $urandom & 32'h3;
            reg_write(map_addr(l, LANE_CTRL), ctrl[l]);
        end
        reg_access(1'b0, ADDR_GLOBAL, '0, q);
        check_word("reg offset", offs, q);
        reg_access(1'b0, ADDR_INTERVAL, '0, q);
        check_word("reg interval", intv, q);
        for (int l = 0; l < NUM_LANES; l++) begin
            reg_access(1'b0, map_addr(l, LANE_CTRL), '0, q);
            check_word($sformatf("reg lane%0d ctrl", l), ctrl[l], q);
        end
        // bitslip is write only and reads as a hole
        foreach (holes[k]) begin
            reg_access(1'b0, holes[k], '0, q);
            check_word("reg unmapped", '0, q);
        end
        for (int l = 0; l < NUM_LANES; l++) reg_write(map_addr(l, LANE_CTRL), '0);
        report_test("registers", e0);
    endtask

    task automatic run_row(input row_t r);
        word_t q;
        int t;
        int e0;
        e0 = errors;
        rx_data.delete();
        rx_lane.delete();
        data_seen = 0;
        corrupt_k[r.lane] = (r.src == SRC_CORRUPT) ? r.count : 0;
        restart_lane(r.lane, r.skew);
        // lane reset clears the slip before the s mod 4 slips
        reg_write(map_addr(r.lane, LANE_CTRL), 32'h2);
        reg_write(map_addr(r.lane, LANE_CTRL), 32'h0);
        for (int k = 0; k < r.skew % 4; k++) reg_write(map_addr(r.lane, LANE_BITSLIP), '0);
        // strobe lands one cycle past the skew's nibble phase
        reg_write(ADDR_GLOBAL, word_t'((1 + r.skew / 4) % NIBBLES_PER_WORD));
        reg_write(ADDR_INTERVAL, word_t'(TEST_INTERVAL));
        if (r.src == SRC_DATA) begin
            reg_write(map_addr(r.lane, LANE_CTRL), 32'h1);
            data_left[r.lane] = r.count;
            t = 0;
            while (data_seen < r.exp_res && t < 4000) begin
                @(negedge cin_clk_i);
                t++;
            end
            if (data_seen < r.exp_res) begin
                errors++;
                $display("timeout waiting for data words on lane %0d", r.lane);
            end
            reg_write(map_addr(r.lane, LANE_CTRL), 32'h0);
            wait_cycles(40);
            // training words around the data carry the lane number too
            foreach (rx_data[k]) begin
                check_lane("resp_lane_o", lane_idx_t'(r.lane), rx_lane[k]);
                if (rx_data[k] == TRAIN_WORD) continue;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("extra data word %h on the response port", rx_data[k]);
                end else begin
                    check_word("resp_data_o", exp_q.pop_front(), rx_data[k]);
                end
            end
            check_count("words still missing", 0, exp_q.size());
            exp_q.delete();
        end else begin
            wait_cycles(SETTLE_CYCLES);
            reg_access(1'b0, map_addr(r.lane, LANE_ERRCNT), '0, q);
            check_errcnt($sformatf("lane%0d errcnt", r.lane), errcnt_t'(r.exp_res),
                         errcnt_t'(q));
            // lane reset returns the count to zero
            reg_write(map_addr(r.lane, LANE_CTRL), 32'h2);
            reg_access(1'b0, map_addr(r.lane, LANE_ERRCNT), '0, q);
            check_errcnt("errcnt after lane reset", '0, errcnt_t'(q));
            reg_write(map_addr(r.lane, LANE_CTRL), 32'h0);
        end
        corrupt_k[r.lane] = 0;
        report_test($sformatf("row lane%0d s%0d", r.lane, r.skew), e0);
    endtask

    task automatic test_backpressure();
        word_t q;
        int t;
        int mask;
        int e0;
        e0 = errors;
        rx_data.delete();
        rx_lane.delete();
        credit_en = 1'b0;
        reg_write(ADDR_OVERFLOW, 32'hF);
        for (int l = 0; l < NUM_LANES; l++) reg_write(map_addr(l, LANE_CTRL), 32'h1);
        // long enough for every lane to drop at least one word
        wait_cycles(100);
        check_count("words without credit", RESP_CREDITS, rx_data.size());
        reg_access(1'b0, ADDR_OVERFLOW, '0, q);
        check_word("overflow bits", 32'hF, q);
        // stop new drops before clearing
        for (int l = 0; l < NUM_LANES; l++) reg_write(map_addr(l, LANE_CTRL), 32'h0);
        reg_write(ADDR_OVERFLOW, 32'hF);
        reg_access(1'b0, ADDR_OVERFLOW, '0, q);
        check_word("overflow after clear", '0, q);
        credit_en = 1'b1;
        credit_kick = RESP_CREDITS;
        t = 0;
        while (rx_data.size() < 2 * RESP_CREDITS && t < 400) begin
            @(negedge cin_clk_i);
            t++;
        end
        wait_cycles(20);
        check_count("words after credit return", 2 * RESP_CREDITS, rx_data.size());
        // one held word per lane follows the credit return
        mask = 0;
        for (int k = RESP_CREDITS; k < rx_lane.size(); k++) mask |= 1 << rx_lane[k];
        check_count("lanes of held words", (1 << NUM_LANES) - 1, mask);
        report_test("backpressure", e0);
    endtask

    initial begin
        void'($urandom(25));
        rst = 1'b1;
        reg_wr_i = 1'b0;
        reg_rd_i = 1'b0;
        reg_addr_i = '0;
        reg_wdata_i = '0;
        lane_nibble_i = '0;
        resp_credit_i = 1'b0;
        restart_req = '0;
        credit_en = 1'b1;
        credit_kick = 0;
        data_seen = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_buf[l] = '0;
            lane_fill[l] = 0;
            word_idx[l] = 0;
            corrupt_k[l] = 0;
            data_left[l] = 0;
            skew_req[l] = 0;
        end
        // columns are lane, skew, source, word or bad word count and expected result
        rows[0] = '{0, 0, SRC_TRAIN, 0, 0};
        rows[1] = '{1, 7, SRC_TRAIN, 0, 0};
        rows[2] = '{2, 18, SRC_TRAIN, 0, 0};
        rows[3] = '{3, 31, SRC_TRAIN, 0, 0};
        rows[4] = '{1, 22, SRC_CORRUPT, 3, 3};
        rows[5] = '{2, 5, SRC_CORRUPT, 1, 1};
        rows[6] = '{0, 13, SRC_DATA, 6, 6};
        repeat (10) @(posedge cin_clk_i);
        @(negedge cin_clk_i);
        rst = 1'b0;
        test_registers();
        for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i]);
        test_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/cin_lane_align.sv ====
`default_nettype none

module cin_lane_align
    import turfio_pkg::*;
(
    input  wire           cin_clk_i,
    input  wire           rst,
    input  wire           lane_rst_i,
    input  wire  nibble_t nibble_i,
    input  wire           bitslip_i,
    input  wire  offset_t offset_i,
    output word_t         word_o,
    output logic          word_stb_o
);

    // nibble from the previous cycle, bit 0 oldest
    nibble_t prev_nibble;
    // two nibbles back to back, older one in the low half
    logic [2*LANE_W-1:0] pair;
    // four bits starting at the slip position
    nibble_t picked;
    // bit slip count, wraps modulo 4
    slip_t slip;
    // free running word phase
    offset_t phase;
    // assembled nibbles, newest enters at the top
    word_t word_sr;

    assign pair = {nibble_i, prev_nibble};

    // slip 0 takes the previous nibble as is,
    // larger slips pull bits from the current one
    assign picked = pair[slip +: LANE_W];

    always_ff @(posedge cin_clk_i) begin
        prev_nibble <= nibble_i;
        // after 8 shifts the oldest nibble sits in bits 3:0
        word_sr <= {picked, word_sr[WORD_W-1:LANE_W]};
    end

    // slip count, cleared by global or lane reset
    always_ff @(posedge cin_clk_i) begin
        if (rst || lane_rst_i) begin
            slip <= '0;
        end else if (bitslip_i) begin
            slip <= slip + 1'b1;
        end
    end

    // phase steps 0..7 and is shared in timing by all lanes
    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            phase <= '0;
        end else if (phase == offset_t'(NIBBLES_PER_WORD - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // the word register holds the last eight picked nibbles,
    // so it is complete whenever the phase hits the offset
    assign word_o = word_sr;
    assign word_stb_o = (phase == offset_i);

endmodule

`default_nettype wire

// ==== design/cin_response_mux.sv ====
`default_nettype none

module cin_response_mux
    import turfio_pkg::*;
(
    input  wire                   cin_clk_i,
    input  wire                   rst,
    input  wire  word_t           lane_word_i [NUM_LANES],
    input  wire  [NUM_LANES-1:0]  lane_stb_i,
    input  wire  [NUM_LANES-1:0]  lane_enable_i,
    input  wire                   resp_credit_i,
    output logic                  resp_valid_o,
    output lane_idx_t             resp_lane_o,
    output word_t                 resp_data_o,
    output logic [NUM_LANES-1:0]  overflow_o
);

    // one word of storage per lane
    word_t hold_data [NUM_LANES];
    logic [NUM_LANES-1:0] hold_full;
    // credits left at the consumer
    logic [CREDIT_W-1:0] credit_cnt;
    // one extra bit before the clamp
    logic [CREDIT_W:0] credit_sum;
    // lane to look at first
    lane_idx_t rr_ptr;
    lane_idx_t pick_lane;
    logic pick_found;
    logic send;
    logic [NUM_LANES-1:0] sent;
    logic [NUM_LANES-1:0] capture;
    logic [NUM_LANES-1:0] accept;
    logic [NUM_LANES-1:0] drop;

    // first full hold register at or after rr_ptr
    always_comb begin
        lane_idx_t cand;
        pick_found = 1'b0;
        pick_lane = rr_ptr;
        for (int k = 0; k < NUM_LANES; k++) begin
            cand = lane_idx_t'((int'(rr_ptr) + k) % NUM_LANES);
            if (!pick_found && hold_full[cand]) begin
                pick_found = 1'b1;
                pick_lane = cand;
            end
        end
    end

    // the word on the output now already owns one credit
    assign send = pick_found && (credit_cnt > CREDIT_W'(resp_valid_o));

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            sent[i] = send && (pick_lane == lane_idx_t'(i));
            capture[i] = lane_stb_i[i] && lane_enable_i[i];
            // a register emptied this cycle can take the new word
            accept[i] = capture[i] && (!hold_full[i] || sent[i]);
            drop[i] = capture[i] && hold_full[i] && !sent[i];
        end
    end

    // spend on valid, refund on credit return
    assign credit_sum = (CREDIT_W + 1)'(credit_cnt) + (CREDIT_W + 1)'(resp_credit_i)
                      - (CREDIT_W + 1)'(resp_valid_o);

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            resp_valid_o <= 1'b0;
            overflow_o <= '0;
            hold_full <= '0;
            rr_ptr <= '0;
            credit_cnt <= CREDIT_W'(RESP_CREDITS);
        end else begin
            resp_valid_o <= send;
            overflow_o <= drop;
            if (credit_sum > (CREDIT_W + 1)'(RESP_CREDITS)) begin
                credit_cnt <= CREDIT_W'(RESP_CREDITS);
            end else begin
                credit_cnt <= credit_sum[CREDIT_W-1:0];
            end
            // next search starts past the lane just served
            if (send) begin
                rr_ptr <= lane_idx_t'((int'(pick_lane) + 1) % NUM_LANES);
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (accept[i]) begin
                    hold_full[i] <= 1'b1;
                end else if (sent[i]) begin
                    hold_full[i] <= 1'b0;
                end
            end
        end
    end

    // payload path
    always_ff @(posedge cin_clk_i) begin
        if (send) begin
            resp_lane_o <= pick_lane;
            resp_data_o <= hold_data[pick_lane];
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (accept[i]) begin
                hold_data[i] <= lane_word_i[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/cin_train_monitor.sv ====
`default_nettype none

module cin_train_monitor
    import turfio_pkg::*;
(
    input  wire             cin_clk_i,
    input  wire             rst,
    input  wire             lane_rst_i,
    input  wire  word_t     word_i,
    input  wire             word_stb_i,
    input  wire             enable_i,
    input  wire  interval_t interval_i,
    output errcnt_t         errcnt_o
);

    // words seen in the current interval
    interval_t word_cnt;
    // mismatching words in the current interval
    errcnt_t err_cnt;
    interval_t word_cnt_nxt;
    errcnt_t err_cnt_nxt;
    logic mismatch;
    logic interval_done;

    assign mismatch = (word_i != TRAIN_WORD);
    assign word_cnt_nxt = word_cnt + 1'b1;
    assign err_cnt_nxt = err_cnt + errcnt_t'(mismatch);

    // interval of zero never latches,
    // >= catches an interval lowered below the running count
    assign interval_done = (interval_i != '0) && (word_cnt_nxt >= interval_i);

    always_ff @(posedge cin_clk_i) begin
        if (rst || lane_rst_i) begin
            word_cnt <= '0;
            err_cnt <= '0;
            errcnt_o <= '0;
        end else if (word_stb_i && !enable_i) begin
            // training only runs while the lane is not forwarding data
            if (interval_done) begin
                errcnt_o <= err_cnt_nxt;
                word_cnt <= '0;
                err_cnt <= '0;
            end else begin
                word_cnt <= word_cnt_nxt;
                err_cnt <= err_cnt_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/turfio_cin_top.sv ====
`default_nettype none

module turfio_cin_top
    import turfio_pkg::*;
(
    input  wire                           cin_clk_i,
    input  wire                           rst,
    input  wire                           reg_wr_i,
    input  wire                           reg_rd_i,
    input  wire  reg_addr_t               reg_addr_i,
    input  wire  word_t                   reg_wdata_i,
    output logic                          reg_ack_o,
    output word_t                         reg_rdata_o,
    input  wire  [NUM_LANES*LANE_W-1:0]   lane_nibble_i,
    output logic                          resp_valid_o,
    output lane_idx_t                     resp_lane_o,
    output word_t                         resp_data_o,
    input  wire                           resp_credit_i
);

    // controls fanned out from the register block
    wire offset_t offset;
    wire interval_t interval;
    wire [NUM_LANES-1:0] lane_enable;
    wire [NUM_LANES-1:0] lane_rst;
    wire [NUM_LANES-1:0] bitslip;
    // per lane results
    wire word_t lane_word [NUM_LANES];
    wire [NUM_LANES-1:0] lane_stb;
    wire errcnt_t lane_errcnt [NUM_LANES];
    wire [NUM_LANES-1:0] overflow;

    turfio_ctl_regs u_regs (
        .cin_clk_i     (cin_clk_i),
        .rst           (rst),
        .reg_wr_i      (reg_wr_i),
        .reg_rd_i      (reg_rd_i),
        .reg_addr_i    (reg_addr_i),
        .reg_wdata_i   (reg_wdata_i),
        .reg_ack_o     (reg_ack_o),
        .reg_rdata_o   (reg_rdata_o),
        .lane_errcnt_i (lane_errcnt),
        .overflow_i    (overflow),
        .offset_o      (offset),
        .interval_o    (interval),
        .lane_enable_o (lane_enable),
        .lane_rst_o    (lane_rst),
        .bitslip_o     (bitslip)
    );

    // one aligner and one training monitor per lane
    for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
        cin_lane_align u_align (
            .cin_clk_i  (cin_clk_i),
            .rst        (rst),
            .lane_rst_i (lane_rst[n]),
            .nibble_i   (lane_nibble_i[n*LANE_W +: LANE_W]),
            .bitslip_i  (bitslip[n]),
            .offset_i   (offset),
            .word_o     (lane_word[n]),
            .word_stb_o (lane_stb[n])
        );

        cin_train_monitor u_monitor (
            .cin_clk_i  (cin_clk_i),
            .rst        (rst),
            .lane_rst_i (lane_rst[n]),
            .word_i     (lane_word[n]),
            .word_stb_i (lane_stb[n]),
            .enable_i   (lane_enable[n]),
            .interval_i (interval),
            .errcnt_o   (lane_errcnt[n])
        );
    end

    cin_response_mux u_resp_mux (
        .cin_clk_i     (cin_clk_i),
        .rst           (rst),
        .lane_word_i   (lane_word),
        .lane_stb_i    (lane_stb),
        .lane_enable_i (lane_enable),
        .resp_credit_i (resp_credit_i),
        .resp_valid_o  (resp_valid_o),
        .resp_lane_o   (resp_lane_o),
        .resp_data_o   (resp_data_o),
        .overflow_o    (overflow)
    );

endmodule

`default_nettype wire

// ==== design/turfio_ctl_regs.sv ====
`default_nettype none

module turfio_ctl_regs
    import turfio_pkg::*;
(
    input  wire                   cin_clk_i,
    input  wire                   rst,
    input  wire                   reg_wr_i,
    input  wire                   reg_rd_i,
    input  wire  reg_addr_t       reg_addr_i,
    input  wire  word_t           reg_wdata_i,
    output logic                  reg_ack_o,
    output word_t                 reg_rdata_o,
    input  wire  errcnt_t         lane_errcnt_i [NUM_LANES],
    input  wire  [NUM_LANES-1:0]  overflow_i,
    output offset_t               offset_o,
    output interval_t             interval_o,
    output logic [NUM_LANES-1:0]  lane_enable_o,
    output logic [NUM_LANES-1:0]  lane_rst_o,
    output logic [NUM_LANES-1:0]  bitslip_o
);

    // global write strobes
    logic wr_global;
    logic wr_interval;
    logic wr_overflow;
    // per lane write strobes
    logic [NUM_LANES-1:0] wr_ctrl;
    logic [NUM_LANES-1:0] wr_slip;
    // sticky drop flags
    logic [NUM_LANES-1:0] overflow_q;
    // write 1 to clear
    logic [NUM_LANES-1:0] overflow_clr;
    word_t rd_mux;

    // address of one register in a lane's block
    function automatic reg_addr_t lane_addr(input int lane, input int reg_off);
        lane_addr = reg_addr_t'(int'(ADDR_LANE_BASE) + lane * LANE_STRIDE + reg_off);
    endfunction

    assign wr_global = reg_wr_i && (reg_addr_i == ADDR_GLOBAL);
    assign wr_interval = reg_wr_i && (reg_addr_i == ADDR_INTERVAL);
    assign wr_overflow = reg_wr_i && (reg_addr_i == ADDR_OVERFLOW);
    assign overflow_clr = wr_overflow ? reg_wdata_i[NUM_LANES-1:0] : '0;

    always_comb begin
        for (int n = 0; n < NUM_LANES; n++) begin
            wr_ctrl[n] = reg_wr_i && (reg_addr_i == lane_addr(n, LANE_CTRL));
            // data is ignored, any write is one slip
            wr_slip[n] = reg_wr_i && (reg_addr_i == lane_addr(n, LANE_BITSLIP));
        end
    end

    always_ff @(posedge cin_clk_i) begin
        if (rst) begin
            reg_ack_o <= 1'b0;
            offset_o <= '0;
            interval_o <= '0;
            lane_enable_o <= '0;
            lane_rst_o <= '0;
            bitslip_o <= '0;
            overflow_q <= '0;
        end else begin
            // every request is answered on the next cycle
            reg_ack_o <= reg_wr_i || reg_rd_i;
            bitslip_o <= wr_slip;
            if (wr_global) begin
                offset_o <= reg_wdata_i[OFFSET_W-1:0];
            end
            if (wr_interval) begin
                interval_o <= reg_wdata_i[INTERVAL_W-1:0];
            end
            for (int n = 0; n < NUM_LANES; n++) begin
                if (wr_ctrl[n]) begin
                    lane_enable_o[n] <= reg_wdata_i[0];
                    // lane reset is a level, held until written back to 0
                    lane_rst_o[n] <= reg_wdata_i[1];
                end
            end
            // a new drop wins over a clear in the same cycle
            overflow_q <= (overflow_q & ~overflow_clr) | overflow_i;
        end
    end

    // readback select, unmapped and write-only addresses give zero
    always_comb begin
        rd_mux = '0;
        if (reg_addr_i == ADDR_GLOBAL) begin
            rd_mux = word_t'(offset_o);
        end else if (reg_addr_i == ADDR_INTERVAL) begin
            rd_mux = word_t'(interval_o);
        end else if (reg_addr_i == ADDR_OVERFLOW) begin
            rd_mux = word_t'(overflow_q);
        end
        for (int n = 0; n < NUM_LANES; n++) begin
            if (reg_addr_i == lane_addr(n, LANE_CTRL)) begin
                rd_mux = word_t'({lane_rst_o[n], lane_enable_o[n]});
            end
            if (reg_addr_i == lane_addr(n, LANE_ERRCNT)) begin
                rd_mux = word_t'(lane_errcnt_i[n]);
            end
        end
    end

    // read data lines up with the acknowledge
    always_ff @(posedge cin_clk_i) begin
        if (reg_rd_i) begin
            reg_rdata_o <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== design/turfio_pkg.sv ====
`default_nettype none

package turfio_pkg;

    // lane and word geometry
    localparam int NUM_LANES = 4;
    localparam int LANE_W = 4;
    localparam int WORD_W = 32;
    // WORD_W / LANE_W, one word per phase cycle
    localparam int NIBBLES_PER_WORD = 8;
    localparam int OFFSET_W = 3;
    localparam int SLIP_W = 2;
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    // idle pattern sent by the remote end while training
    localparam logic [WORD_W-1:0] TRAIN_WORD = 32'hA55A6996;

    // response stream flow control
    localparam int RESP_CREDITS = 4;
    localparam int CREDIT_W = $clog2(RESP_CREDITS + 1);

    // register port and counters
    localparam int REG_ADDR_W = 6;
    localparam int INTERVAL_W = 16;
    localparam int ERRCNT_W = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LANE_W-1:0] nibble_t;
    typedef logic [LANE_IDX_W-1:0] lane_idx_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [SLIP_W-1:0] slip_t;
    typedef logic [ERRCNT_W-1:0] errcnt_t;
    typedef logic [INTERVAL_W-1:0] interval_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // register map
    localparam reg_addr_t ADDR_GLOBAL = 'h00;
    localparam reg_addr_t ADDR_INTERVAL = 'h01;
    localparam reg_addr_t ADDR_OVERFLOW = 'h02;
    localparam reg_addr_t ADDR_LANE_BASE = 'h10;
    localparam int LANE_STRIDE = 4;
    // offsets inside one lane's block
    localparam int LANE_CTRL = 0;
    localparam int LANE_BITSLIP = 1;
    localparam int LANE_ERRCNT = 2;

endpackage

`default_nettype wire

// ==== flist.f ====
design/turfio_pkg.sv
design/cin_lane_align.sv
design/cin_train_monitor.sv
design/cin_response_mux.sv
design/turfio_ctl_regs.sv
design/turfio_cin_top.sv
bench/turfio_cin_assertions.sv
bench/turfio_cin_tb.sv
